// ==== vlog.f ====
game_pkg.sv
lives_tracker.sv
level_ctrl.sv
score_counter.sv
status_arbiter.sv
status_regs.sv
game_core.sv
game_core_assert.sv
tb_game_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the game_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
  --top-module tb_game_core \
  -f vlog.f \
  --Mdir obj_dir \
  -o sim_tb_game_core

./obj_dir/sim_tb_game_core | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed."
  exit 0
fi

echo "Simulation failed, see sim.log."
exit 1

// ==== tb_game_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_game_core;

  import game_pkg::*;

  localparam int cycle_limit = 10000;   // About twice the expected run length.

  logic               pclk;
  logic               rst;
  logic               hit;
  logic               bonus;
  logic               target;
  logic [addr_w-1:0]  rd_addr;
  wire  [stat_w-1:0]  rd_data;
  wire  [level_w-1:0] level;
  wire                level_up;
  wire                lives_1;
  wire                lives_2;
  wire                lives_3;
  wire                lives_4;
  wire                lives_5;
  wire                game_over;

  int          m_lives;
  int          m_level;
  int          m_state;                 // 0 armed, 1 raising, 2 waiting for full lives.
  logic        m_level_up;
  logic [15:0] m_score;
  logic        model_valid = 1'b0;

  logic [31:0] lfsr;
  int          cycles = 0;
  int          pulses = 0;              // Level-up pulses seen so far.
  int          cmp_errors = 0;
  int          seq_errors = 0;
  int          err_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  game_core u_dut (
    .pclk      (pclk),
    .rst       (rst),
    .hit       (hit),
    .bonus     (bonus),
    .target    (target),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .level     (level),
    .level_up  (level_up),
    .lives_1   (lives_1),
    .lives_2   (lives_2),
    .lives_3   (lives_3),
    .lives_4   (lives_4),
    .lives_5   (lives_5),
    .game_over (game_over)
  );

  always #5 pclk = ~pclk;

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  function automatic logic [4:0] thermometer(input int n);
    logic [4:0] t;
    for (int i = 0; i < 5; i++) begin
      t[i] = (n > i);
    end
    return t;
  endfunction

  // Returns 1 on a mismatch.
  function automatic int check_val(input string name, input int got, input int exp_val);
    assert (got == exp_val) else begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, got);
      return 1;
    end
    return 0;
  endfunction

  task automatic expect_eq(input string name, input int got, input int exp_val);
    seq_errors = seq_errors + check_val(name, got, exp_val);
  endtask

  task automatic drive(input logic h, input logic b, input logic t);
    @(negedge pclk);
    hit    = h;
    bonus  = b;
    target = t;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, 1'b0);
  endtask

  task automatic host_read(input logic [addr_w-1:0] addr, input int exp_val,
                           input string name);
    drive(1'b0, 1'b0, 1'b0);
    rd_addr = addr;
    @(negedge pclk);
    expect_eq(name, int'(rd_data), exp_val);
  endtask

  task automatic apply_reset();
    rst    = 1'b1;
    hit    = 1'b0;
    bonus  = 1'b0;
    target = 1'b0;
    repeat (3) @(negedge pclk);
    rst = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run = tests_run + 1;
    if (seq_errors + cmp_errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, seq_errors + cmp_errors - err_mark);
      tests_failed = tests_failed + 1;
    end
    err_mark = seq_errors + cmp_errors;
  endtask

  // ==============================
  // Reference model
  // ==============================
  function automatic void clear_model();
    m_lives    = int'(lives_max);
    m_level    = int'(level_min);
    m_state    = 0;
    m_level_up = 1'b0;
    m_score    = '0;
  endfunction

  // One clock edge of the game rules, all read before any update.
  function automatic void step_model(input logic h, input logic b, input logic t);
    logic full;
    full       = (m_lives == int'(lives_max));
    m_level_up = 1'b0;
    if (t) begin
      m_score = m_score + 16'(m_level);           // Level before this edge.
    end
    case (m_state)
      0: if (!full) m_state = 1;                  // Fifth life lost.
      1: begin
        if (m_level < int'(level_max)) begin
          m_level    = m_level + 1;
          m_level_up = 1'b1;
        end
        m_state = 2;
      end
      default: if (full) m_state = 0;
    endcase
    if (h && !b && m_lives > 0) begin
      m_lives = m_lives - 1;
    end else if (b && !h && m_lives < int'(lives_max)) begin
      m_lives = m_lives + 1;
    end
  endfunction

  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (rst) begin
      clear_model();
      model_valid = 1'b1;
    end else if (model_valid) begin
      step_model(hit, bonus, target);
    end
  end

  // Outputs are compared on the falling edge, away from the DUT's updates.
  always @(negedge pclk) begin
    if (model_valid) begin
      cmp_errors = cmp_errors + check_val("lives",
        int'({lives_5, lives_4, lives_3, lives_2, lives_1}), int'(thermometer(m_lives)));
      cmp_errors = cmp_errors + check_val("game_over", int'(game_over), int'(m_lives == 0));
      cmp_errors = cmp_errors + check_val("level", int'(level), m_level);
      cmp_errors = cmp_errors + check_val("level_up", int'(level_up), int'(m_level_up));
      if (level_up) begin
        pulses = pulses + 1;
      end
    end
  end

  initial begin
    wait (cycles >= cycle_limit);
    $display("Timeout: the tests did not finish within %0d cycles.", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int   start;
    int   p0;
    int   exp_level;
    int   s0;
    logic b1;
    logic b2;
    logic b3;
    logic b4;
    logic b5;
    pclk    = 1'b0;
    rd_addr = '0;
    lfsr    = 32'h1dc0;
    apply_reset();

    expect_eq("lives", int'({lives_5, lives_4, lives_3, lives_2, lives_1}), 31);
    expect_eq("level", int'(level), 1);
    expect_eq("level_up", int'(level_up), 0);
    expect_eq("game_over", int'(game_over), 0);
    host_read(addr_lives, 5, "rd_data lives");
    host_read(addr_level, 1, "rd_data level");
    host_read(addr_score, 0, "rd_data score");
    report_test("test 1 reset values");

    repeat (5) drive(1'b1, 1'b0, 1'b0);
    idle(1);
    expect_eq("lives", int'({lives_5, lives_4, lives_3, lives_2, lives_1}), 0);
    expect_eq("game_over", int'(game_over), 1);
    repeat (2) drive(1'b1, 1'b0, 1'b0);          // Already at zero.
    idle(1);
    expect_eq("lives", int'({lives_5, lives_4, lives_3, lives_2, lives_1}), 0);
    repeat (7) drive(1'b0, 1'b1, 1'b0);          // Two more than needed.
    idle(1);
    expect_eq("lives", int'({lives_5, lives_4, lives_3, lives_2, lives_1}), 31);
    expect_eq("game_over", int'(game_over), 0);
    repeat (2) drive(1'b1, 1'b1, 1'b0);
    drive(1'b1, 1'b0, 1'b0);
    drive(1'b1, 1'b1, 1'b0);
    idle(1);
    expect_eq("lives", int'({lives_5, lives_4, lives_3, lives_2, lives_1}), 15);
    drive(1'b0, 1'b1, 1'b0);
    idle(3);
    report_test("test 2 lives saturation");

    start = m_level;
    p0    = pulses;
    drive(1'b1, 1'b0, 1'b0);
    idle(4);                                      // Pulse is over and counted.
    expect_eq("level", int'(level), start + 1);
    expect_eq("level_up pulse count", pulses - p0, 1);
    repeat (2) drive(1'b1, 1'b0, 1'b0);          // Lives 3 then 2, no new pulse.
    idle(3);
    expect_eq("level_up pulse count", pulses - p0, 1);
    repeat (3) drive(1'b0, 1'b1, 1'b0);
    idle(2);
    for (int r = 2; r <= 16; r++) begin
      drive(1'b1, 1'b0, 1'b0);
      idle(3);
      drive(1'b0, 1'b1, 1'b0);
      idle(2);
      exp_level = (start + r > 15) ? 15 : start + r;
      expect_eq("level", int'(level), exp_level);
      expect_eq("level_up pulse count", pulses - p0, exp_level - start);
    end
    report_test("test 3 level rule");

    s0 = int'(m_score);
    repeat (10) drive(1'b0, 1'b0, 1'b1);
    idle(4);
    host_read(addr_score, int'(16'(s0 + 10 * m_level)), "rd_data score");
    repeat (4400) drive(1'b0, 1'b0, 1'b1);       // Enough to pass 65535.
    idle(4);
    host_read(addr_score, int'(16'(s0 + 4410 * m_level)), "rd_data score");
    report_test("test 4 score");

    apply_reset();
    repeat (10) begin
      repeat (20) begin
        take_bit(b1);
        take_bit(b2);
        take_bit(b3);
        take_bit(b4);
        take_bit(b5);
        drive(b1 & b2, b3 & b4, b5);
      end
      idle(4);
      host_read(addr_lives, m_lives, "rd_data lives");
      host_read(addr_level, m_level, "rd_data level");
      host_read(addr_score, int'(m_score), "rd_data score");
    end
    report_test("test 5 contention");

    host_read(2'd3, 0, "rd_data unused");
    @(negedge pclk);
    rd_addr = addr_lives;
    @(negedge pclk);
    expect_eq("rd_data lives", int'(rd_data), m_lives);
    rd_addr = 2'd3;
    @(negedge pclk);
    expect_eq("rd_data unused", int'(rd_data), 0);
    rd_addr = addr_score;
    @(negedge pclk);
    expect_eq("rd_data score", int'(rd_data), int'(m_score));
    report_test("test 6 read port");

    $display("tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             seq_errors + cmp_errors);
    if (seq_errors + cmp_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== game_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_core_assert (
  input wire                         pclk,
  input wire                         rst,
  input wire [game_pkg::n_peers-1:0] req,
  input wire [game_pkg::n_peers-1:0] grant,
  input wire [game_pkg::level_w-1:0] level,
  input wire                         level_up
);

  import game_pkg::*;

  // A pending write stays requested until its grant.
  req_held: assert property (@(posedge pclk) disable iff (rst)
    1'b1 |=> (($past(req & ~grant) & ~req) == '0))
    else $error("a write request was dropped before its grant");

  level_up_single: assert property (@(posedge pclk) disable iff (rst) level_up |=> !level_up)
    else $error("level_up stayed high for two cycles");

  level_floor: assert property (@(posedge pclk) disable iff (rst) level >= level_min)
    else $error("level fell below its minimum");

endmodule

bind game_core game_core_assert u_assert (
  .pclk     (pclk),
  .rst      (rst),
  .req      (req),
  .grant    (grant),
  .level    (level),
  .level_up (level_up)
);

`default_nettype wire

// ==== game_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_core (
  input  wire                         pclk,
  input  wire                         rst,
  input  wire                         hit,
  input  wire                         bonus,
  input  wire                         target,
  input  wire  [game_pkg::addr_w-1:0]  rd_addr,
  output wire  [game_pkg::stat_w-1:0]  rd_data,
  output wire  [game_pkg::level_w-1:0] level,
  output wire                         level_up,
  output wire                         lives_1,
  output wire                         lives_2,
  output wire                         lives_3,
  output wire                         lives_4,
  output wire                         lives_5,
  output wire                         game_over
);

  import game_pkg::*;

  // ============================
  // Internal nets
  // ============================
  wire [n_peers-1:0] req;
  wire [n_peers-1:0] grant;
  wire [stat_w-1:0]  lives_data;
  wire [stat_w-1:0]  level_data;
  wire [stat_w-1:0]  score_data;
  wire               wr_en;
  wire [addr_w-1:0]  wr_addr;
  wire [stat_w-1:0]  wr_data;

  lives_tracker u_lives (
    .pclk      (pclk),
    .rst       (rst),
    .hit       (hit),
    .bonus     (bonus),
    .grant     (grant[peer_lives]),
    .lives_1   (lives_1),
    .lives_2   (lives_2),
    .lives_3   (lives_3),
    .lives_4   (lives_4),
    .lives_5   (lives_5),
    .game_over (game_over),
    .req       (req[peer_lives]),
    .wr_data   (lives_data)
  );

  level_ctrl u_level (
    .pclk     (pclk),
    .rst      (rst),
    .lives_5  (lives_5),
    .grant    (grant[peer_level]),
    .level    (level),
    .level_up (level_up),
    .req      (req[peer_level]),
    .wr_data  (level_data)
  );

  // The score reaches the host only through the status memory.
  score_counter u_score (
    .pclk    (pclk),
    .rst     (rst),
    .target  (target),
    .level   (level),
    .grant   (grant[peer_score]),
    .score   (),
    .req     (req[peer_score]),
    .wr_data (score_data)
  );

  status_arbiter u_arb (
    .req        (req),
    .grant      (grant),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .lives_data (lives_data),
    .level_data (level_data),
    .score_data (score_data)
  );

  status_regs u_regs (
    .pclk    (pclk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== status_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_regs (
  input  wire                         pclk,
  input  wire                         rst,
  input  wire                         wr_en,
  input  wire  [game_pkg::addr_w-1:0]  wr_addr,
  input  wire  [game_pkg::stat_w-1:0]  wr_data,
  input  wire  [game_pkg::addr_w-1:0]  rd_addr,
  output logic [game_pkg::stat_w-1:0]  rd_data
);

  import game_pkg::*;

  logic [stat_w-1:0] lives_q;
  logic [stat_w-1:0] level_q;
  logic [stat_w-1:0] score_q;

  // Write port, preloaded with the game's reset state.
  always_ff @(posedge pclk) begin
    if (rst) begin
      lives_q <= stat_w'(lives_max);
      level_q <= stat_w'(level_min);
      score_q <= stat_w'(score_rst);
    end else if (wr_en) begin
      case (wr_addr)
        addr_lives: lives_q <= wr_data;
        addr_level: level_q <= wr_data;
        addr_score: score_q <= wr_data;
        default:    ;                           // Unused slot.
      endcase
    end
  end

  // Host read, one cycle behind rd_addr.
  always_ff @(posedge pclk) begin
    case (rd_addr)
      addr_lives: rd_data <= lives_q;
      addr_level: rd_data <= level_q;
      addr_score: rd_data <= score_q;
      default:    rd_data <= '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== status_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_arbiter (
  input  wire  [game_pkg::n_peers-1:0] req,
  output logic [game_pkg::n_peers-1:0] grant,
  output logic                        wr_en,
  output logic [game_pkg::addr_w-1:0]  wr_addr,
  output logic [game_pkg::stat_w-1:0]  wr_data,
  input  wire  [game_pkg::stat_w-1:0]  lives_data,
  input  wire  [game_pkg::stat_w-1:0]  level_data,
  input  wire  [game_pkg::stat_w-1:0]  score_data
);

  import game_pkg::*;

  // ============================
  // Fixed priority select
  // ============================
  // Lives first, then level, then score.
  always_comb begin
    grant   = '0;
    wr_addr = addr_lives;
    wr_data = lives_data;
    if (req[peer_lives]) begin
      grant[peer_lives] = 1'b1;
    end else if (req[peer_level]) begin
      grant[peer_level] = 1'b1;
      wr_addr           = addr_level;
      wr_data           = level_data;
    end else if (req[peer_score]) begin
      grant[peer_score] = 1'b1;
      wr_addr           = addr_score;
      wr_data           = score_data;
    end
  end

  assign wr_en = |req;                          // Any request wins a slot.

endmodule

`default_nettype wire

// ==== score_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_counter (
  input  wire                         pclk,
  input  wire                         rst,
  input  wire                         target,
  input  wire  [game_pkg::level_w-1:0] level,
  input  wire                         grant,
  output logic [game_pkg::score_w-1:0] score,
  output logic                        req,
  output logic [game_pkg::stat_w-1:0]  wr_data
);

  import game_pkg::*;

  logic pend;

  // ============================
  // Accumulator
  // ============================
  always_ff @(posedge pclk) begin
    if (rst) begin
      score <= score_rst;
      pend  <= 1'b0;
    end else begin
      if (target) begin
        score <= score + score_w'(level);       // Wraps at score_w bits.
      end
      // Level is never zero, so every target changes the score.
      pend <= target | (pend & ~grant);
    end
  end

  assign req     = pend;
  assign wr_data = stat_w'(score);

endmodule

`default_nettype wire

// ==== level_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_ctrl (
  input  wire                         pclk,
  input  wire                         rst,
  input  wire                         lives_5,
  input  wire                         grant,
  output logic [game_pkg::level_w-1:0] level,
  output logic                        level_up,
  output logic                        req,
  output logic [game_pkg::stat_w-1:0]  wr_data
);

  import game_pkg::*;

  typedef enum logic [1:0] {
    st_armed = 2'b00,   // Waiting for the fifth life to go.
    st_raise = 2'b01,   // One cycle, the level steps here.
    st_wait  = 2'b10    // Waiting for full lives again.
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   step;
  logic   pend;

  // ============================
  // Next state
  // ============================
  always_comb begin
    state_nxt = state;
    case (state)
      st_armed: if (!lives_5) state_nxt = st_raise;
      st_raise: state_nxt = st_wait;
      st_wait:  if (lives_5) state_nxt = st_armed;   // Re-arm on full lives.
      default:  state_nxt = st_armed;
    endcase
  end

  // No step and no pulse once the ceiling is reached.
  assign step = (state == st_raise) && (level != level_max);

  // ============================
  // Registers
  // ============================
  always_ff @(posedge pclk) begin
    if (rst) begin
      state    <= st_armed;
      level    <= level_min;
      level_up <= 1'b0;
      pend     <= 1'b0;
    end else begin
      state    <= state_nxt;
      level_up <= step;                         // One-cycle pulse.
      pend     <= step | (pend & ~grant);
      if (step) begin
        level <= level + 1'b1;
      end
    end
  end

  assign req     = pend;
  assign wr_data = stat_w'(level);

endmodule

`default_nettype wire

// ==== lives_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lives_tracker (
  input  wire                        pclk,
  input  wire                        rst,
  input  wire                        hit,
  input  wire                        bonus,
  input  wire                        grant,
  output logic                       lives_1,
  output logic                       lives_2,
  output logic                       lives_3,
  output logic                       lives_4,
  output logic                       lives_5,
  output logic                       game_over,
  output logic                       req,
  output logic [game_pkg::stat_w-1:0] wr_data
);

  import game_pkg::*;

  logic [lives_w-1:0] count;
  logic [lives_w-1:0] count_nxt;
  logic               pend;

  // Saturating count, a hit and a bonus together cancel.
  always_comb begin
    count_nxt = count;
    if (hit && !bonus && (count != '0)) begin
      count_nxt = count - 1'b1;                 // Lose one life.
    end else if (bonus && !hit && (count != lives_max)) begin
      count_nxt = count + 1'b1;                 // Restore one life.
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      count <= lives_max;
      pend  <= 1'b0;
    end else begin
      count <= count_nxt;
      // A fresh change keeps the flag set even while granted.
      pend  <= (count_nxt != count) | (pend & ~grant);
    end
  end

  // Thermometer view of the count.
  assign lives_1   = (count >= 3'd1);
  assign lives_2   = (count >= 3'd2);
  assign lives_3   = (count >= 3'd3);
  assign lives_4   = (count >= 3'd4);
  assign lives_5   = (count >= 3'd5);
  assign game_over = (count == '0);             // No lives left.

  assign req     = pend;
  assign wr_data = stat_w'(count);              // Zero-extended status word.

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

  // ============================
  // Widths
  // ============================
  localparam int lives_w = 3;   // Holds 0 to lives_max.
  localparam int level_w = 4;
  localparam int score_w = 16;  // Score wraps at this width.
  localparam int stat_w  = 16;  // One status word.
  localparam int addr_w  = 2;

  // ============================
  // Limits and reset values
  // ============================
  localparam logic [lives_w-1:0] lives_max = 3'd5;   // Also the lives reset value.
  localparam logic [level_w-1:0] level_min = 4'd1;   // Level after reset.
  localparam logic [level_w-1:0] level_max = 4'd15;  // Level ceiling.
  localparam logic [score_w-1:0] score_rst = '0;

  // ============================
  // Status map and arbiter
  // ============================
  // Address 3 is unused and reads zero.
  localparam logic [addr_w-1:0] addr_lives = 2'd0;
  localparam logic [addr_w-1:0] addr_level = 2'd1;
  localparam logic [addr_w-1:0] addr_score = 2'd2;

  localparam int n_peers = 3;

  // Request and grant bit positions, lowest index wins.
  localparam int peer_lives = 0;
  localparam int peer_level = 1;
  localparam int peer_score = 2;

endpackage

`default_nettype wire
